// File: hw/mapper_pkg.sv
/*
 * MSX cartridge mapper definitions
 * Mapper and device encodings, slot configuration, bank widths
 * and the bank-to-ROM address helpers shared by all mappers
 */
package mapper_pkg;

    localparam int BANK_W     = 8;   // Bank register width
    localparam int ROM_AW_MAX = 21;  // Widest ROM address, 2 MB
    localparam int PAGE8_W    = 13;  // Offset bits in an 8 KB bank
    localparam int PAGE16_W   = 14;  // Offset bits in a 16 KB bank

    // Bank switching scheme of the slot
    typedef enum logic [2:0] {
        none       = 3'd0,
        ascii8     = 3'd1,
        ascii16    = 3'd2,
        konami     = 3'd3,
        konami_scc = 3'd4
    } mapper_t;

    // Device claimed by an access instead of ROM
    typedef enum logic {
        dev_none = 1'b0,
        dev_scc  = 1'b1
    } device_t;

    typedef logic [BANK_W-1:0]     bank_t;
    typedef logic [ROM_AW_MAX-1:0] rom_addr_t;

    typedef struct packed {
        mapper_t   mapper;    // Active scheme
        rom_addr_t rom_mask;  // Ones up to the cartridge size
    } block_info_t;

    // Flat ROM address of an 8 KB banked access
    function automatic rom_addr_t page8_addr(input bank_t bank, input logic [15:0] addr);
        return rom_addr_t'({bank, addr[PAGE8_W-1:0]});
    endfunction

    // Flat ROM address of a 16 KB banked access, top bit drops off
    function automatic rom_addr_t page16_addr(input bank_t bank, input logic [15:0] addr);
        return rom_addr_t'({bank, addr[PAGE16_W-1:0]});
    endfunction

endpackage

// File: hw/mapper_ifs.sv
/*
 * Cartridge slot bus interfaces
 * cpu_bus is the shared CPU access bus watched by every mapper,
 * mapper_out is one mapper's memory and device request
 */
`timescale 1ns/1ns

interface cpu_bus (
    input logic clk,
    input logic rst
);

    logic [15:0] addr;  // CPU address
    logic [7:0]  din;   // CPU write data
    logic        rd;    // One-cycle read strobe
    logic        wr;    // One-cycle write strobe

    // Mappers only watch the bus
    modport mapper (
        input clk,
        input rst,
        input addr,
        input din,
        input rd,
        input wr
    );

    modport source (
        input  clk,
        input  rst,
        output addr,
        output din,
        output rd,
        output wr
    );

endinterface

interface mapper_out #(
    parameter int ROM_AW = 20
);

    logic [ROM_AW-1:0]   addr;     // All ones when idle
    logic                rnw;      // One when idle
    logic                cs;       // ROM select
    mapper_pkg::device_t dev_typ;  // dev_none when idle
    logic                dev_en;

    modport drv (output addr, output rnw, output cs, output dev_typ, output dev_en);
    modport sink (input addr, input rnw, input cs, input dev_typ, input dev_en);

endinterface

// File: hw/mapper_ascii8.sv
/*
 * ASCII8 mapper
 * Four 8 KB banks over 4000h-BFFFh, bank n loaded by a write
 * into 6000h-7FFFh with address bits 12:11 equal to n
 */
`timescale 1ns/1ns

module mapper_ascii8 #(
    parameter int ROM_AW = 20
) (
    cpu_bus.mapper                 bus,
    input mapper_pkg::block_info_t info,
    mapper_out.drv                 out
);

    mapper_pkg::bank_t     bank_q [4];  // Bank per 8 KB page
    logic                  active;
    logic                  in_win;      // 4000h-BFFFh
    logic                  reg_wr;
    logic [1:0]            page;
    logic                  hit;
    mapper_pkg::rom_addr_t rom_addr;

    assign active = (info.mapper == mapper_pkg::ascii8);
    assign in_win = (bus.addr[15:14] == 2'b01) || (bus.addr[15:14] == 2'b10);
    assign reg_wr = active && bus.wr && (bus.addr[15:13] == 3'b011);  // 6000h-7FFFh
    assign page   = bus.addr[14:13] - 2'd2;  // 4000h maps to page 0
    assign hit    = active && in_win && (bus.rd || bus.wr);

    // Bank registers
    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= '0;
            end
        end else if (reg_wr) begin
            bank_q[bus.addr[12:11]] <= bus.din;  // Register picked by bits 12:11
        end
    end

    assign rom_addr = mapper_pkg::page8_addr(bank_q[page], bus.addr) & info.rom_mask;

    // Neutral values when idle so the combiner can AND/OR
    assign out.addr    = hit ? rom_addr[ROM_AW-1:0] : '1;
    assign out.rnw     = ~(hit && bus.wr);  // Register writes also reach ROM
    assign out.cs      = hit;
    assign out.dev_typ = mapper_pkg::dev_none;  // No device behind ASCII8
    assign out.dev_en  = 1'b0;

endmodule

// File: hw/mapper_ascii16.sv
/*
 * ASCII16 mapper
 * Two 16 KB banks, 4000h-7FFFh and 8000h-BFFFh, loaded by
 * writes into 6000h-67FFh and 7000h-77FFh
 */
`timescale 1ns/1ns

module mapper_ascii16 #(
    parameter int ROM_AW = 20
) (
    cpu_bus.mapper                 bus,
    input mapper_pkg::block_info_t info,
    mapper_out.drv                 out
);

    mapper_pkg::bank_t     bank_q [2];
    logic                  active;
    logic                  in_win;
    logic                  reg_wr;
    logic                  hit;
    mapper_pkg::rom_addr_t rom_addr;

    assign active = (info.mapper == mapper_pkg::ascii16);
    assign in_win = (bus.addr[15:14] == 2'b01) || (bus.addr[15:14] == 2'b10);
    // 6000h-67FFh or 7000h-77FFh, bit 12 picks the bank
    assign reg_wr = active && bus.wr && (bus.addr[15:13] == 3'b011) && !bus.addr[11];
    assign hit    = active && in_win && (bus.rd || bus.wr);

    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            bank_q[0] <= '0;
            bank_q[1] <= '0;
        end else if (reg_wr) begin
            bank_q[bus.addr[12]] <= bus.din;
        end
    end

    // Bit 15 splits the window into its two 16 KB halves
    assign rom_addr = mapper_pkg::page16_addr(bank_q[bus.addr[15]], bus.addr) & info.rom_mask;

    assign out.addr    = hit ? rom_addr[ROM_AW-1:0] : '1;
    assign out.rnw     = ~(hit && bus.wr);
    assign out.cs      = hit;
    assign out.dev_typ = mapper_pkg::dev_none;
    assign out.dev_en  = 1'b0;

endmodule

// File: hw/mapper_konami.sv
/*
 * Konami mapper without SCC
 * Page 4000h is fixed to bank 0, the three pages above it
 * follow the bank written anywhere inside that page
 */
`timescale 1ns/1ns

module mapper_konami #(
    parameter int ROM_AW = 20
) (
    cpu_bus.mapper                 bus,
    input mapper_pkg::block_info_t info,
    mapper_out.drv                 out
);

    mapper_pkg::bank_t     bank_q [1:3];  // Switchable pages only
    mapper_pkg::bank_t     cur_bank;
    logic                  active;
    logic                  in_win;
    logic [1:0]            page;
    logic                  hit;
    mapper_pkg::rom_addr_t rom_addr;

    assign active = (info.mapper == mapper_pkg::konami);
    assign in_win = (bus.addr[15:14] == 2'b01) || (bus.addr[15:14] == 2'b10);
    assign page   = bus.addr[14:13] - 2'd2;
    assign hit    = active && in_win && (bus.rd || bus.wr);

    // Reset maps page i to bank i
    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            for (int i = 1; i <= 3; i++) begin
                bank_q[i] <= mapper_pkg::bank_t'(i);
            end
        end else if (active && bus.wr && in_win) begin
            for (int i = 1; i <= 3; i++) begin
                if (page == 2'(i)) begin
                    bank_q[i] <= bus.din;  // Writes to page 0 are dropped
                end
            end
        end
    end

    always_comb begin
        case (page)
            2'd1:    cur_bank = bank_q[1];
            2'd2:    cur_bank = bank_q[2];
            2'd3:    cur_bank = bank_q[3];
            default: cur_bank = '0;  // Fixed first page
        endcase
    end

    assign rom_addr = mapper_pkg::page8_addr(cur_bank, bus.addr) & info.rom_mask;

    assign out.addr    = hit ? rom_addr[ROM_AW-1:0] : '1;
    assign out.rnw     = ~(hit && bus.wr);
    assign out.cs      = hit;
    assign out.dev_typ = mapper_pkg::dev_none;
    assign out.dev_en  = 1'b0;

endmodule

// File: hw/mapper_konami_scc.sv
/*
 * Konami SCC mapper
 * Four 8 KB banks loaded from 5000h, 7000h, 9000h and B000h,
 * plus the SCC window at 9800h-9FFFh when bank 2 holds 3Fh
 */
`timescale 1ns/1ns

module mapper_konami_scc #(
    parameter int ROM_AW = 20
) (
    cpu_bus.mapper                 bus,
    input mapper_pkg::block_info_t info,
    mapper_out.drv                 out
);

    mapper_pkg::bank_t     bank_q [4];
    logic                  active;
    logic                  in_win;
    logic                  strobe;
    logic [1:0]            page;
    logic                  reg_wr;
    logic                  scc_on;    // SCC window mapped in
    logic                  scc_hit;
    logic                  hit;
    mapper_pkg::rom_addr_t rom_addr;

    assign active = (info.mapper == mapper_pkg::konami_scc);
    assign in_win = (bus.addr[15:14] == 2'b01) || (bus.addr[15:14] == 2'b10);
    assign strobe = bus.rd || bus.wr;
    assign page   = bus.addr[14:13] - 2'd2;
    // x000h-x7FFh in the upper half of each page, so 5000h, 7000h, 9000h, B000h
    assign reg_wr = active && bus.wr && in_win && (bus.addr[12:11] == 2'b10);

    // Reset maps page i to bank i
    always_ff @(posedge bus.clk) begin
        if (bus.rst) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= mapper_pkg::bank_t'(i);
            end
        end else if (reg_wr) begin
            bank_q[page] <= bus.din;
        end
    end

    // Only the low six bits of bank 2 enable the chip
    assign scc_on  = (bank_q[2][5:0] == 6'h3F);
    assign scc_hit = active && strobe && scc_on && (bus.addr[15:11] == 5'b10011);
    assign hit     = active && in_win && strobe && !scc_hit;  // SCC steals the access

    assign rom_addr = mapper_pkg::page8_addr(bank_q[page], bus.addr) & info.rom_mask;

    assign out.addr    = hit ? rom_addr[ROM_AW-1:0] : '1;
    assign out.rnw     = ~(hit && bus.wr);
    assign out.cs      = hit;
    assign out.dev_typ = scc_hit ? mapper_pkg::dev_scc : mapper_pkg::dev_none;
    assign out.dev_en  = scc_hit;

endmodule

// File: hw/mappers.sv
/*
 * Mapper set of one cartridge slot
 * Every mapper watches the CPU bus, only the configured one
 * answers, and idle outputs are neutral for the AND/OR merge
 */
`timescale 1ns/1ns

module mappers #(
    parameter int ROM_AW = 20
) (
    cpu_bus.mapper                  bus,
    input  mapper_pkg::block_info_t info,
    output logic [ROM_AW-1:0]       mem_addr,
    output logic                    mem_rnw,
    output logic                    mem_cs,
    output mapper_pkg::device_t     dev_typ,
    output logic                    dev_en,
    output logic                    dev_we
);

    mapper_out #(.ROM_AW(ROM_AW)) ascii8_out ();
    mapper_out #(.ROM_AW(ROM_AW)) ascii16_out ();
    mapper_out #(.ROM_AW(ROM_AW)) konami_out ();
    mapper_out #(.ROM_AW(ROM_AW)) konami_scc_out ();

    mapper_ascii8 #(.ROM_AW(ROM_AW)) ascii8 (
        .bus  (bus),
        .info (info),
        .out  (ascii8_out)
    );

    mapper_ascii16 #(.ROM_AW(ROM_AW)) ascii16 (
        .bus  (bus),
        .info (info),
        .out  (ascii16_out)
    );

    mapper_konami #(.ROM_AW(ROM_AW)) konami (
        .bus  (bus),
        .info (info),
        .out  (konami_out)
    );

    mapper_konami_scc #(.ROM_AW(ROM_AW)) konami_scc (
        .bus  (bus),
        .info (info),
        .out  (konami_scc_out)
    );

    // Idle mappers drive ones on addr and rnw
    assign mem_addr = ascii8_out.addr & ascii16_out.addr & konami_out.addr & konami_scc_out.addr;
    assign mem_rnw  = ascii8_out.rnw & ascii16_out.rnw & konami_out.rnw & konami_scc_out.rnw;
    // ...and zeros on selects and device lines
    assign mem_cs   = ascii8_out.cs | ascii16_out.cs | konami_out.cs | konami_scc_out.cs;
    assign dev_typ  = mapper_pkg::device_t'(ascii8_out.dev_typ | ascii16_out.dev_typ
                                          | konami_out.dev_typ | konami_scc_out.dev_typ);
    assign dev_en   = ascii8_out.dev_en | ascii16_out.dev_en
                    | konami_out.dev_en | konami_scc_out.dev_en;
    assign dev_we   = dev_en & bus.wr;  // Device write only on the write strobe

endmodule

// File: hw/cart_slot.sv
/*
 * Cartridge slot top level
 * Bundles the CPU pins into the slot bus and the configuration
 * pins into the block info, then hands both to the mapper set
 */
`timescale 1ns/1ns

module cart_slot #(
    parameter int ROM_AW = 20  // 17 to 21
) (
    input  logic                clk,
    input  logic                rst,
    input  mapper_pkg::mapper_t cfg_mapper,    // Needs a reset after a change
    input  logic [ROM_AW-1:0]   cfg_rom_mask,
    input  logic [15:0]         cpu_addr,
    input  logic [7:0]          cpu_din,
    input  logic                cpu_rd,        // One cycle per access
    input  logic                cpu_wr,
    output logic [ROM_AW-1:0]   mem_addr,
    output logic                mem_rnw,
    output logic                mem_cs,
    output mapper_pkg::device_t dev_typ,
    output logic                dev_en,
    output logic                dev_we
);

    mapper_pkg::block_info_t info;

    cpu_bus bus (
        .clk (clk),
        .rst (rst)
    );

    assign bus.addr = cpu_addr;
    assign bus.din  = cpu_din;
    assign bus.rd   = cpu_rd;
    assign bus.wr   = cpu_wr;

    assign info.mapper   = cfg_mapper;
    assign info.rom_mask = mapper_pkg::rom_addr_t'(cfg_rom_mask);  // Zero above ROM_AW

    mappers #(.ROM_AW(ROM_AW)) i_mappers (
        .bus      (bus),
        .info     (info),
        .mem_addr (mem_addr),
        .mem_rnw  (mem_rnw),
        .mem_cs   (mem_cs),
        .dev_typ  (dev_typ),
        .dev_en   (dev_en),
        .dev_we   (dev_we)
    );

endmodule

// File: include/mapper_ref.svh
/*
 * Reference model of the cartridge slot mappers
 * Shadow bank registers updated after each CPU write, and the
 * expected ROM or device response of any CPU access
 */
`ifndef MAPPER_REF_SVH
`define MAPPER_REF_SVH

typedef struct packed {
    mapper_pkg::rom_addr_t addr;    // All ones unless the access reaches ROM
    logic                  cs;
    logic                  rnw;
    mapper_pkg::device_t   dev;
    logic                  dev_en;
} ref_exp_t;

mapper_pkg::mapper_t   ref_mapper;
mapper_pkg::rom_addr_t ref_mask;
mapper_pkg::bank_t     ref_bank [4];  // Konami keeps page 0 at zero

// Konami types start with page i at bank i
task automatic load_model(input mapper_pkg::mapper_t m, input mapper_pkg::rom_addr_t mask);
    ref_mapper = m;
    ref_mask   = mask;
    for (int i = 0; i < 4; i++) begin
        if (m == mapper_pkg::konami || m == mapper_pkg::konami_scc)
            ref_bank[i] = mapper_pkg::bank_t'(i);
        else
            ref_bank[i] = '0;
    end
endtask

// Call one edge after the write
task automatic track_write(input logic [15:0] a, input mapper_pkg::bank_t d);
    logic [1:0] page;
    logic       in_win;
    page   = 2'((a - 16'h4000) >> 13);
    in_win = (a >= 16'h4000) && (a <= 16'hBFFF);
    case (ref_mapper)
        mapper_pkg::ascii8: begin
            if (a >= 16'h6000 && a <= 16'h7FFF) ref_bank[2'((a - 16'h6000) >> 11)] = d;
        end
        mapper_pkg::ascii16: begin
            if (a >= 16'h6000 && a <= 16'h67FF) ref_bank[0] = d;
            if (a >= 16'h7000 && a <= 16'h77FF) ref_bank[1] = d;
        end
        mapper_pkg::konami: begin
            if (in_win && page != 2'd0) ref_bank[page] = d;  // Page 4000h stays fixed
        end
        mapper_pkg::konami_scc: begin
            // 2 KB select ranges at 5000h, 7000h, 9000h and B000h
            if ((a >= 16'h5000 && a <= 16'h57FF) || (a >= 16'h7000 && a <= 16'h77FF)
                || (a >= 16'h9000 && a <= 16'h97FF) || (a >= 16'hB000 && a <= 16'hB7FF))
                ref_bank[page] = d;
        end
        default: ;
    endcase
endtask

// Expected response of a read or, with wr set, of a write
function automatic ref_exp_t expected_response(input logic [15:0] a, input logic wr);
    ref_exp_t              e;
    mapper_pkg::bank_t     bank;
    mapper_pkg::rom_addr_t flat;
    e      = '{addr: '1, cs: 1'b0, rnw: 1'b1, dev: mapper_pkg::dev_none, dev_en: 1'b0};
    bank   = ref_bank[2'((a - 16'h4000) >> 13)];
    if (ref_mapper == mapper_pkg::none || a < 16'h4000 || a > 16'hBFFF) return e;
    if (ref_mapper == mapper_pkg::konami_scc && ref_bank[2][5:0] == 6'h3F
        && a >= 16'h9800 && a <= 16'h9FFF) begin
        e.dev    = mapper_pkg::dev_scc;
        e.dev_en = 1'b1;
        return e;
    end
    if (ref_mapper == mapper_pkg::ascii16) begin
        bank = (a < 16'h8000) ? ref_bank[0] : ref_bank[1];
        flat = (mapper_pkg::rom_addr_t'(bank) << 14) | mapper_pkg::rom_addr_t'(a[13:0]);
    end else begin
        flat = (mapper_pkg::rom_addr_t'(bank) << 13) | mapper_pkg::rom_addr_t'(a[12:0]);
    end
    e.addr = flat & ref_mask;
    e.cs   = 1'b1;
    e.rnw  = !wr;  // Bank writes also show up as ROM writes
    return e;
endfunction

`endif

// File: bench/tb_cart_slot.sv
/*
 * Testbench for the cartridge slot mappers
 * Runs each mapper type after a reset with directed and random
 * CPU accesses and checks every cycle against the reference model
 */
`timescale 1ns/1ns

module tb_cart_slot;

    localparam int ROM_AW      = 20;
    localparam int RUNS        = 5;    // none plus four mapper types
    localparam int RST_CYC     = 8;
    localparam int N_RAND      = 150;  // Random accesses per run
    localparam int N_ACC       = 200;  // Upper bound of accesses per run
    localparam int CYC_PER_ACC = 2;    // Strobe cycle plus idle cycle
    localparam int LIMIT       = RUNS * (RST_CYC + N_ACC * CYC_PER_ACC) * 2;

    logic                clk;
    logic                rst;
    mapper_pkg::mapper_t cfg_mapper;
    logic [ROM_AW-1:0]   cfg_rom_mask;
    logic [15:0]         cpu_addr;
    logic [7:0]          cpu_din;
    logic                cpu_rd;
    logic                cpu_wr;
    logic [ROM_AW-1:0]   mem_addr;
    logic                mem_rnw;
    logic                mem_cs;
    mapper_pkg::device_t dev_typ;
    logic                dev_en;
    logic                dev_we;

    integer seed = 32'he8db;
    int     n_checks = 0;
    int     mem_errors = 0;
    int     dev_errors = 0;
    int     cycles = 0;

    `include "mapper_ref.svh"

    cart_slot #(.ROM_AW(ROM_AW)) i_dut (
        .clk          (clk),
        .rst          (rst),
        .cfg_mapper   (cfg_mapper),
        .cfg_rom_mask (cfg_rom_mask),
        .cpu_addr     (cpu_addr),
        .cpu_din      (cpu_din),
        .cpu_rd       (cpu_rd),
        .cpu_wr       (cpu_wr),
        .mem_addr     (mem_addr),
        .mem_rnw      (mem_rnw),
        .mem_cs       (mem_cs),
        .dev_typ      (dev_typ),
        .dev_en       (dev_en),
        .dev_we       (dev_we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // ROM side of the slot
    task automatic check_mem(input logic [ROM_AW-1:0] exp_addr, input logic exp_cs,
                             input logic exp_rnw);
        if (mem_addr !== exp_addr) begin
            $display("Mismatch mem_addr at cpu_addr %04h: got %05h, expected %05h",
                     cpu_addr, mem_addr, exp_addr);
            mem_errors++;
        end
        if (mem_cs !== exp_cs) begin
            $display("Mismatch mem_cs at cpu_addr %04h: got %0h, expected %0h",
                     cpu_addr, mem_cs, exp_cs);
            mem_errors++;
        end
        if (mem_rnw !== exp_rnw) begin
            $display("Mismatch mem_rnw at cpu_addr %04h: got %0h, expected %0h",
                     cpu_addr, mem_rnw, exp_rnw);
            mem_errors++;
        end
    endtask

    // Device side with SCC select and its write enable
    task automatic check_dev(input mapper_pkg::device_t exp_typ, input logic exp_en,
                             input logic exp_we);
        if (dev_typ !== exp_typ) begin
            $display("Mismatch dev_typ at cpu_addr %04h: got %0h, expected %0h",
                     cpu_addr, dev_typ, exp_typ);
            dev_errors++;
        end
        if (dev_en !== exp_en) begin
            $display("Mismatch dev_en at cpu_addr %04h: got %0h, expected %0h",
                     cpu_addr, dev_en, exp_en);
            dev_errors++;
        end
        if (dev_we !== exp_we) begin
            $display("Mismatch dev_we at cpu_addr %04h: got %0h, expected %0h",
                     cpu_addr, dev_we, exp_we);
            dev_errors++;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin : compare
        ref_exp_t e;
        if (!rst) begin
            if (cpu_rd || cpu_wr)
                e = expected_response(cpu_addr, cpu_wr);
            else
                e = '{addr: '1, cs: 1'b0, rnw: 1'b1, dev: mapper_pkg::dev_none, dev_en: 1'b0};
            check_mem(e.addr[ROM_AW-1:0], e.cs, e.rnw);
            check_dev(e.dev, e.dev_en, e.dev_en & cpu_wr);  // Write enable only on writes
            if (cpu_wr) track_write(cpu_addr, cpu_din);  // Model banks move before the next edge
            n_checks++;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: stimulus still running after %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // New configuration always goes in under reset
    task automatic reset_run(input mapper_pkg::mapper_t m, input logic [ROM_AW-1:0] mask);
        @(posedge clk);
        rst          <= 1'b1;
        cfg_mapper   <= m;
        cfg_rom_mask <= mask;
        cpu_rd       <= 1'b0;
        cpu_wr       <= 1'b0;
        load_model(m, mapper_pkg::rom_addr_t'(mask));
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
    endtask

    // One strobe cycle followed by one idle cycle
    task automatic access(input logic [15:0] a, input logic [7:0] d, input logic wr);
        @(posedge clk);
        cpu_addr <= a;
        cpu_din  <= d;
        cpu_wr   <= wr;
        cpu_rd   <= !wr;
        @(posedge clk);
        cpu_rd <= 1'b0;
        cpu_wr <= 1'b0;
    endtask

    task automatic pick_write(input mapper_pkg::mapper_t m, output logic [15:0] a,
                              output logic [7:0] d);
        logic [31:0] r;
        r = $random(seed);
        d = r[23:16];
        if (r[31:29] == 3'd0) begin
            a = r[15:0];  // Anywhere in the address space
        end else begin
            case (m)
                mapper_pkg::ascii8:     a = 16'h6000 | {3'b000, r[12:0]};
                mapper_pkg::ascii16:    a = (r[11] ? 16'h7000 : 16'h6000) | {5'b0, r[10:0]};
                mapper_pkg::konami:     a = 16'h4000 + {1'b0, r[14:0]};
                mapper_pkg::konami_scc: a = {3'({1'b0, r[14:13]} + 3'd2), 2'b10, r[10:0]};
                default:                a = r[15:0];
            endcase
        end
        if (m == mapper_pkg::konami_scc && r[25:24] == 2'd0)
            d = {r[27:26], 6'h3F};  // Values that map the SCC in
    endtask

    task automatic pick_read(input mapper_pkg::mapper_t m, output logic [15:0] a);
        logic [31:0] r;
        r = $random(seed);
        if (r[31:29] == 3'd0)
            a = r[15:0];
        else if (m == mapper_pkg::konami_scc && r[28:27] == 2'd0)
            a = {5'b10011, r[10:0]};  // SCC window
        else
            a = 16'h4000 + {1'b0, r[14:0]};
    endtask

    task automatic random_run(input mapper_pkg::mapper_t m);
        logic [31:0] r;
        logic [15:0] a;
        logic [7:0]  d;
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            if (r[1:0] == 2'd0) begin
                pick_write(m, a, d);
                access(a, d, 1'b1);
            end else begin
                pick_read(m, a);
                access(a, 8'h00, 1'b0);
            end
        end
    endtask

    // One read per page plus both window edges
    task automatic page_sweep();
        access(16'h4000, 8'h00, 1'b0);
        access(16'h6000, 8'h00, 1'b0);
        access(16'h8000, 8'h00, 1'b0);
        access(16'hA000, 8'h00, 1'b0);
        access(16'h3FFF, 8'h00, 1'b0);
        access(16'hC000, 8'h00, 1'b0);
        access(16'h0000, 8'h5A, 1'b1);
    endtask

    task automatic konami_fixed_page();
        access(16'h4000, 8'h35, 1'b1);  // Ignored by the bank logic
        access(16'h5FFF, 8'h00, 1'b0);
        access(16'h4ABC, 8'h00, 1'b0);
        access(16'h8000, 8'h0A, 1'b1);
        access(16'h8123, 8'h00, 1'b0);
    endtask

    task automatic scc_window();
        access(16'h9000, 8'h3F, 1'b1);
        access(16'h9800, 8'h00, 1'b0);
        access(16'h9FFF, 8'h55, 1'b1);  // Device write
        access(16'h9C21, 8'h00, 1'b0);
        access(16'h9000, 8'h12, 1'b1);  // SCC mapped out again
        access(16'h9800, 8'h00, 1'b0);
        access(16'h9ABC, 8'h77, 1'b1);
        access(16'h9000, 8'h7F, 1'b1);  // Low six bits still 3Fh
        access(16'h9900, 8'h00, 1'b0);
        access(16'h9000, 8'h3E, 1'b1);
        access(16'h9900, 8'h00, 1'b0);
    endtask

    task automatic run_mapper(input mapper_pkg::mapper_t m, input logic [ROM_AW-1:0] mask);
        reset_run(m, mask);
        page_sweep();  // Reset bank mapping
        random_run(m);
        if (m == mapper_pkg::konami) konami_fixed_page();
        if (m == mapper_pkg::konami_scc) scc_window();
        page_sweep();
    endtask

    initial begin
        rst          = 1'b1;
        cfg_mapper   = mapper_pkg::none;
        cfg_rom_mask = '0;
        cpu_addr     = '0;
        cpu_din      = '0;
        cpu_rd       = 1'b0;
        cpu_wr       = 1'b0;

        run_mapper(mapper_pkg::none, 20'hFFFFF);
        run_mapper(mapper_pkg::ascii8, 20'h3FFFF);  // 256 KB cartridge
        run_mapper(mapper_pkg::ascii16, 20'hFFFFF);
        run_mapper(mapper_pkg::konami, 20'h7FFFF);
        run_mapper(mapper_pkg::konami_scc, 20'h1FFFF);
        repeat (2) @(posedge clk);

        $display("Checks %0d, mem errors %0d, dev errors %0d", n_checks, mem_errors, dev_errors);
        if (mem_errors + dev_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
hw/mapper_pkg.sv
hw/mapper_ifs.sv
hw/mapper_ascii8.sv
hw/mapper_ascii16.sv
hw/mapper_konami.sv
hw/mapper_konami_scc.sv
hw/mappers.sv
hw/cart_slot.sv
bench/tb_cart_slot.sv

// File: Makefile
# Verilator build for the cartridge slot mappers

LOG = sim.log
OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module cart_slot

sim:
	verilator --binary --timing -f filelist.f --top-module tb_cart_slot \
		--Mdir $(OBJ) -o tb_cart_slot
	./$(OBJ)/tb_cart_slot | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
